// File: av_core_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// shared types and default timing for the a/v core
////////////////////////////////////////////////////////////

package av_core_pkg;

    // raster coordinate width, enough for 512 lines
    localparam int COORD_W = 10;

    typedef logic [COORD_W-1:0] coord_t;

    // 24-bit colour, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // current counter position plus active-region flag
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
    } raster_pos_t;

    typedef struct packed {
        logic vs;
        logic hs;
    } video_sync_t;

    typedef struct packed {
        logic de;
        rgb_t rgb;
    } pixel_t;

    // what the scaler sees
    typedef struct packed {
        video_sync_t sync;
        pixel_t      pixel;
    } video_out_t;

    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

    ////////////////////////////////////////////////////////////
    // default raster, 320x240 inside 400x512 at 12.288 MHz
    ////////////////////////////////////////////////////////////
    localparam int DEF_H_TOTAL   = 400;
    localparam int DEF_H_ACTIVE  = 320;
    localparam int DEF_H_BPORCH  = 10;
    localparam int DEF_V_TOTAL   = 512;
    localparam int DEF_V_ACTIVE  = 240;
    localparam int DEF_V_BPORCH  = 10;
    // hs a few pixels after vs, never on the same cycle
    localparam int DEF_HS_OFFSET = 3;

    // overlay band limits, raw counter values
    localparam int DEF_OVL_X_END   = 60;
    localparam int DEF_OVL_Y_START = 200;

    // colours
    localparam logic [7:0] GREY_LEVEL = 8'd60;
    localparam rgb_t COLOUR_RED   = '{red: 8'd255, green: 8'd0, blue: 8'd0};
    localparam rgb_t COLOUR_BLACK = '{red: 8'd0, green: 8'd0, blue: 8'd0};

    // i2s, mclk/4 bit clock and 32 bits per channel
    localparam int DEF_MCLK_PER_SCLK = 4;
    localparam int DEF_BITS_PER_WORD = 32;

endpackage

`default_nettype wire

// File: raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// raster counters, sync pulses, active-region flag
////////////////////////////////////////////////////////////

module raster_timing #(
    parameter int H_TOTAL   = 400,
    parameter int H_ACTIVE  = 320,
    parameter int H_BPORCH  = 10,
    parameter int V_TOTAL   = 512,
    parameter int V_ACTIVE  = 240,
    parameter int V_BPORCH  = 10,
    parameter int HS_OFFSET = 3
) (
    input  wire                       audgen_mclk,
    input  wire                       reset_n,
    output av_core_pkg::raster_pos_t  pos,
    output av_core_pkg::video_sync_t  sync
);

    // pixel and line counters
    av_core_pkg::coord_t x_cnt;
    av_core_pkg::coord_t y_cnt;

    logic x_last;
    logic y_last;
    logic h_active;
    logic v_active;

    // end of line, end of frame
    assign x_last = (x_cnt == av_core_pkg::coord_t'(H_TOTAL - 1));
    assign y_last = (y_cnt == av_core_pkg::coord_t'(V_TOTAL - 1));

    // active window, back porch up to back porch + active
    assign h_active = (x_cnt >= av_core_pkg::coord_t'(H_BPORCH)) &&
                      (x_cnt < av_core_pkg::coord_t'(H_BPORCH + H_ACTIVE));
    assign v_active = (y_cnt >= av_core_pkg::coord_t'(V_BPORCH)) &&
                      (y_cnt < av_core_pkg::coord_t'(V_BPORCH + V_ACTIVE));

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            if (x_last) begin
                x_cnt <= '0;
                // y steps once per line
                if (y_last) begin
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sync pulses, one cycle behind the counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sync <= '0;
        end else begin
            // new frame at (0,0)
            sync.vs <= (x_cnt == '0) && (y_cnt == '0);
            // new line, offset so it never lands on vs
            sync.hs <= (x_cnt == av_core_pkg::coord_t'(HS_OFFSET));
        end
    end

    // position is straight from the counters
    assign pos = '{
        x:      x_cnt,
        y:      y_cnt,
        active: h_active && v_active
    };

endmodule

`default_nettype wire

// File: video_pixel_gen.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// colour and data enable from raster position
////////////////////////////////////////////////////////////

module video_pixel_gen #(
    parameter int OVL_X_END   = 60,
    parameter int OVL_Y_START = 200
) (
    input  wire                       audgen_mclk,
    input  wire                       reset_n,
    input  av_core_pkg::raster_pos_t  pos,
    input  logic                      debug_overlay,
    output av_core_pkg::pixel_t       pixel
);

    logic                 in_left_band;
    logic                 in_bottom_band;
    logic                 paint_red;
    av_core_pkg::rgb_t    grey;
    av_core_pkg::pixel_t  pixel_d;

    // flat grey, same level on every channel
    assign grey = '{
        red:   av_core_pkg::GREY_LEVEL,
        green: av_core_pkg::GREY_LEVEL,
        blue:  av_core_pkg::GREY_LEVEL
    };

    // overlay bands, raw counter compare
    assign in_left_band   = (pos.x < av_core_pkg::coord_t'(OVL_X_END));
    assign in_bottom_band = (pos.y > av_core_pkg::coord_t'(OVL_Y_START));

    // red only while debug level is high
    assign paint_red = debug_overlay && (in_left_band || in_bottom_band);

    ////////////////////////////////////////////////////////////
    // next pixel
    ////////////////////////////////////////////////////////////

    always_comb begin
        pixel_d.de = pos.active;
        // inactive area is black
        pixel_d.rgb = av_core_pkg::COLOUR_BLACK;
        if (pos.active) begin
            if (paint_red) begin
                pixel_d.rgb = av_core_pkg::COLOUR_RED;
            end else begin
                pixel_d.rgb = grey;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    // one cycle after pos, lines up with registered sync
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            pixel <= '0;
        end else begin
            pixel <= pixel_d;
        end
    end

endmodule

`default_nettype wire

// File: i2s_silence_gen.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// silent i2s stream, bit and word clocks from mclk
////////////////////////////////////////////////////////////

module i2s_silence_gen #(
    parameter int MCLK_PER_SCLK = 4,
    parameter int BITS_PER_WORD = 32
) (
    input  wire                    audgen_mclk,
    input  wire                    reset_n,
    output av_core_pkg::i2s_out_t  audio
);

    // both ratios are powers of two
    localparam int DIV_W = $clog2(MCLK_PER_SCLK);
    localparam int BIT_W = $clog2(BITS_PER_WORD);

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             sclk_fall;
    logic             lrck_q;
    logic             dac_q;

    // last divider count, sclk drops on the next edge
    assign sclk_fall = (div_cnt == DIV_W'(MCLK_PER_SCLK - 1));

    // mclk divider
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // bit count and word clock, both on falling sclk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt <= '0;
            lrck_q  <= 1'b0;
            dac_q   <= 1'b0;
        end else begin
            // no samples, line stays low
            dac_q <= 1'b0;
            if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                // switch channels after a full word
                if (bit_cnt == BIT_W'(BITS_PER_WORD - 1)) begin
                    lrck_q <= ~lrck_q;
                end
            end
        end
    end

    // sclk is the divider msb
    assign audio = '{
        sclk: div_cnt[DIV_W-1],
        lrck: lrck_q,
        dac:  dac_q
    };

endmodule

`default_nettype wire

// File: av_core_top.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// a/v generator top, single clock on audgen_mclk
////////////////////////////////////////////////////////////

module av_core_top #(
    parameter int H_TOTAL       = av_core_pkg::DEF_H_TOTAL,
    parameter int H_ACTIVE      = av_core_pkg::DEF_H_ACTIVE,
    parameter int H_BPORCH      = av_core_pkg::DEF_H_BPORCH,
    parameter int V_TOTAL       = av_core_pkg::DEF_V_TOTAL,
    parameter int V_ACTIVE      = av_core_pkg::DEF_V_ACTIVE,
    parameter int V_BPORCH      = av_core_pkg::DEF_V_BPORCH,
    parameter int HS_OFFSET     = av_core_pkg::DEF_HS_OFFSET,
    parameter int OVL_X_END     = av_core_pkg::DEF_OVL_X_END,
    parameter int OVL_Y_START   = av_core_pkg::DEF_OVL_Y_START,
    parameter int MCLK_PER_SCLK = av_core_pkg::DEF_MCLK_PER_SCLK,
    parameter int BITS_PER_WORD = av_core_pkg::DEF_BITS_PER_WORD
) (
    input  wire                      audgen_mclk,
    input  wire                      reset_n,
    input  logic                     debug_overlay,
    output av_core_pkg::video_out_t  video,
    output av_core_pkg::i2s_out_t    audio
);

    av_core_pkg::raster_pos_t pos;
    av_core_pkg::video_sync_t sync;
    av_core_pkg::pixel_t      pixel;

    // counters and sync
    raster_timing #(
        .H_TOTAL   (H_TOTAL),
        .H_ACTIVE  (H_ACTIVE),
        .H_BPORCH  (H_BPORCH),
        .V_TOTAL   (V_TOTAL),
        .V_ACTIVE  (V_ACTIVE),
        .V_BPORCH  (V_BPORCH),
        .HS_OFFSET (HS_OFFSET)
    ) u_raster_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos),
        .sync        (sync)
    );

    // colour and de, aligned with sync
    video_pixel_gen #(
        .OVL_X_END   (OVL_X_END),
        .OVL_Y_START (OVL_Y_START)
    ) u_video_pixel_gen (
        .audgen_mclk   (audgen_mclk),
        .reset_n       (reset_n),
        .pos           (pos),
        .debug_overlay (debug_overlay),
        .pixel         (pixel)
    );

    // silent audio
    i2s_silence_gen #(
        .MCLK_PER_SCLK (MCLK_PER_SCLK),
        .BITS_PER_WORD (BITS_PER_WORD)
    ) u_i2s_silence_gen (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio       (audio)
    );

    // video bundle for the scaler
    assign video = '{sync: sync, pixel: pixel};

endmodule

`default_nettype wire

// File: av_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module av_core_tb;

    ////////////////////////////////////////////////////////////
    // small raster, one frame is 1200 cycles
    ////////////////////////////////////////////////////////////
    localparam int H_TOTAL      = 40;
    localparam int H_ACTIVE     = 20;
    localparam int H_BPORCH     = 4;
    localparam int V_TOTAL      = 30;
    localparam int V_ACTIVE     = 16;
    localparam int V_BPORCH     = 3;
    localparam int HS_OFFSET    = 3;
    localparam int OVL_X_END    = 9;
    localparam int OVL_Y_START  = 14;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYC    = 4;
    // i2s at its defaults
    localparam int SCLK_DIV     = av_core_pkg::DEF_MCLK_PER_SCLK;
    localparam int WORD_CYC     = SCLK_DIV * av_core_pkg::DEF_BITS_PER_WORD;
    localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;
    // seven frames of run plus resets, rounded up to ten
    localparam int WATCHDOG_CYC = 10 * FRAME_CYC;

    logic                    audgen_mclk   = 1'b0;
    logic                    reset_n       = 1'b0;
    logic                    debug_overlay = 1'b0;
    av_core_pkg::video_out_t video;
    av_core_pkg::i2s_out_t   audio;

    // reference model state
    logic              armed     = 1'b0;
    logic              started;
    int                vx;
    int                vy;
    int                acyc;
    logic              ovl_q;
    logic [31:0]       rng_state = 32'haef0;
    logic [31:0]       rng_next;
    logic              exp_vs;
    logic              exp_hs;
    logic              exp_de;
    logic              exp_red;
    logic              exp_sclk;
    logic              exp_lrck;
    av_core_pkg::rgb_t exp_rgb;

    av_core_top #(
        .H_TOTAL     (H_TOTAL),
        .H_ACTIVE    (H_ACTIVE),
        .H_BPORCH    (H_BPORCH),
        .V_TOTAL     (V_TOTAL),
        .V_ACTIVE    (V_ACTIVE),
        .V_BPORCH    (V_BPORCH),
        .HS_OFFSET   (HS_OFFSET),
        .OVL_X_END   (OVL_X_END),
        .OVL_Y_START (OVL_Y_START)
    ) DUT (
        .audgen_mclk   (audgen_mclk),
        .reset_n       (reset_n),
        .debug_overlay (debug_overlay),
        .video         (video),
        .audio         (audio)
    );

    always #(CLK_PERIOD / 2) audgen_mclk = ~audgen_mclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic stop_on_error(input string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("Fail %s expected %0h actual %0h", name, expected, actual);
        stop_on_error($sformatf("check %s failed", name));
    endtask

    // counts vs pulses seen on falling edges
    task automatic wait_frame_starts(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(negedge audgen_mclk);
            if (video.sync.vs) begin
                seen = seen + 1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference position, i.e. what the outputs describe now
    ////////////////////////////////////////////////////////////
    always @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            started <= 1'b0;
            vx      <= 0;
            vy      <= 0;
            acyc    <= 0;
            ovl_q   <= 1'b0;
        end else begin
            // first edge after release shows (0,0)
            started <= 1'b1;
            ovl_q   <= debug_overlay;
            acyc    <= (acyc + 1) % (2 * WORD_CYC);
            if (started) begin
                if (vx == H_TOTAL - 1) begin
                    vx <= 0;
                    vy <= (vy == V_TOTAL - 1) ? 0 : vy + 1;
                end else begin
                    vx <= vx + 1;
                end
            end
        end
    end

    // skip the very first edge, outputs may still be unknown
    always @(posedge audgen_mclk) begin
        armed <= 1'b1;
    end

    assign exp_vs  = started && (vx == 0) && (vy == 0);
    assign exp_hs  = started && (vx == HS_OFFSET);
    assign exp_de  = started && (vx >= H_BPORCH) && (vx < H_BPORCH + H_ACTIVE) &&
                     (vy >= V_BPORCH) && (vy < V_BPORCH + V_ACTIVE);
    // left band or bottom band
    assign exp_red = ovl_q && ((vx < OVL_X_END) || (vy > OVL_Y_START));
    // sclk low then high, lrck flips each word
    assign exp_sclk = (acyc % SCLK_DIV) >= (SCLK_DIV / 2);
    assign exp_lrck = ((acyc / WORD_CYC) % 2) == 1;

    always_comb begin
        exp_rgb = av_core_pkg::COLOUR_BLACK;
        if (exp_de) begin
            if (exp_red) begin
                exp_rgb = av_core_pkg::COLOUR_RED;
            end else begin
                exp_rgb = '{red:   av_core_pkg::GREY_LEVEL,
                            green: av_core_pkg::GREY_LEVEL,
                            blue:  av_core_pkg::GREY_LEVEL};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks at the rising edge
    ////////////////////////////////////////////////////////////
    vs_check: assert property (@(posedge audgen_mclk) !armed || (video.sync.vs == exp_vs))
        else report_mismatch("vertical_sync", int'($sampled(exp_vs)),
                             int'($sampled(video.sync.vs)));
    hs_check: assert property (@(posedge audgen_mclk) !armed || (video.sync.hs == exp_hs))
        else report_mismatch("horizontal_sync", int'($sampled(exp_hs)),
                             int'($sampled(video.sync.hs)));
    de_check: assert property (@(posedge audgen_mclk) !armed || (video.pixel.de == exp_de))
        else report_mismatch("data_enable", int'($sampled(exp_de)),
                             int'($sampled(video.pixel.de)));
    rgb_check: assert property (@(posedge audgen_mclk) !armed || (video.pixel.rgb == exp_rgb))
        else report_mismatch("pixel_colour", int'($sampled(exp_rgb)),
                             int'($sampled(video.pixel.rgb)));
    // black whenever de is low
    blank_check: assert property (@(posedge audgen_mclk)
        !armed || video.pixel.de || (video.pixel.rgb == av_core_pkg::COLOUR_BLACK))
        else report_mismatch("blank_colour", 0, int'($sampled(video.pixel.rgb)));
    sclk_check: assert property (@(posedge audgen_mclk) !armed || (audio.sclk == exp_sclk))
        else report_mismatch("i2s_sclk", int'($sampled(exp_sclk)),
                             int'($sampled(audio.sclk)));
    lrck_check: assert property (@(posedge audgen_mclk) !armed || (audio.lrck == exp_lrck))
        else report_mismatch("i2s_lrck", int'($sampled(exp_lrck)),
                             int'($sampled(audio.lrck)));
    dac_check: assert property (@(posedge audgen_mclk) !armed || !audio.dac)
        else report_mismatch("i2s_dac", 0, int'($sampled(audio.dac)));
    reset_check: assert property (@(posedge audgen_mclk)
        !armed || reset_n || ((video == '0) && (audio == '0)))
        else report_mismatch("reset_outputs", 0,
                             int'({$sampled(video), $sampled(audio)}));

    // new overlay level at every frame start
    assign rng_next = xorshift32(rng_state);

    always @(negedge audgen_mclk) begin
        if (video.sync.vs) begin
            rng_state     <= rng_next;
            debug_overlay <= rng_next[3];
        end
    end

    initial begin
        repeat (RESET_CYC) @(negedge audgen_mclk);
        reset_n = 1'b1;
        // sixth vs closes the fifth frame
        wait_frame_starts(6);
        reset_n = 1'b0;
        repeat (RESET_CYC) @(negedge audgen_mclk);
        reset_n = 1'b1;
        // two more full frames after the restart
        wait_frame_starts(3);
        $display("No errors");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        stop_on_error("watchdog expired before the run finished");
    end

endmodule

`default_nettype wire

// File: av_core_top.f
av_core_pkg.sv
raster_timing.sv
video_pixel_gen.sv
i2s_silence_gen.sv
av_core_top.sv
av_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the av_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module av_core_tb \
    -f av_core_top.f \
    -o av_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/av_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation passed"
exit 0
